// ==== core_isa_pkg.sv ====
// Instruction field positions, opcode encoding, register file sizing and execute states
`default_nettype none

package core_isa_pkg;

    // data path width and register file size
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 4;
    localparam int REG_AW   = $clog2(NUM_REGS);

    // opcode sits in the top nibble and the immediate fills the low half
    localparam int OPC_MSB = 31;
    localparam int OPC_W   = 4;
    localparam int RD_LSB  = 26;
    localparam int RS_LSB  = 24;
    localparam int IMM_W   = 16;

    // codes not listed here retire without any effect
    typedef enum logic [OPC_W-1:0] {
        OP_LDI = 4'h0,
        OP_LUI = 4'h1,
        OP_ADD = 4'h2,
        OP_SUB = 4'h3,
        OP_XOR = 4'h4,
        OP_LW  = 4'h5,
        OP_SW  = 4'h6,
        OP_BNE = 4'h7
    } op_e;

    typedef enum logic [1:0] {
        EX_IDLE,
        EX_RUN,
        EX_MEM_WAIT
    } ex_state_e;

endpackage

`default_nettype wire

// ==== mem_map_pkg.sv ====
// RAM geometry, boot address, pseudo-peripheral addresses and the pass code
`default_nettype none

package mem_map_pkg;

    // word-addressed RAM occupying the bottom of the address space
    localparam int          RAM_WORDS = 256;
    localparam int          RAM_AW    = 8;
    localparam int          WORD_LSB  = 2;
    localparam logic [31:0] RAM_BYTES = 32'(RAM_WORDS * 4);

    localparam logic [31:0] BOOT_ADDR = 32'h0000_0000;

    // writing PASS_CODE here reports a passing test, anything else a failure
    localparam logic [31:0] STATUS_ADDR = 32'h2000_0000;
    localparam logic [31:0] PASS_CODE   = 32'd123456789;

    // a write here ends the program and publishes the written word
    localparam logic [31:0] EXIT_ADDR = 32'h2000_0004;

endpackage

`default_nettype wire

// ==== mem_bus_if.sv ====
// Request/grant/response-valid memory bus with instruction and data modports
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    logic        req;
    logic        gnt;
    logic        rvalid;
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [31:0] rdata;

    // instruction side is read only, so we and wdata stay off these modports
    modport instr_master (output req, addr, input gnt, rvalid, rdata);
    modport instr_slave (input req, addr, output gnt, rvalid, rdata);

    modport data_master (
        output req, addr, we, wdata,
        input  gnt, rvalid, rdata
    );

    modport data_slave (
        input  req, addr, we, wdata,
        output gnt, rvalid, rdata
    );

endinterface

`default_nettype wire

// ==== fetch_if.sv ====
// Fetched-instruction handoff from fetch to execute with the retire and redirect return path
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;
    import core_isa_pkg::*;

    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            valid;
    // done pulses once per retired instruction, redirect only for a taken branch
    logic            done;
    logic            redirect;
    logic [XLEN-1:0] target;

    modport fetch (output instr, pc, valid, input done, redirect, target);
    modport exec (input instr, pc, valid, output done, redirect, target);

endinterface

`default_nettype wire

// ==== fetch_unit.sv ====
// Program counter and single-outstanding instruction fetch
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            fetch_enable_i,
    mem_bus_if.instr_master ibus,
    fetch_if.fetch          fq
);
    import core_isa_pkg::*;
    import mem_map_pkg::*;

    typedef enum logic [1:0] {
        F_IDLE,
        F_REQ,
        F_WAIT,
        F_PRESENT
    } fetch_state_e;

    fetch_state_e    state_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] instr_q;

    // request is held in F_REQ until the RAM grants it
    assign ibus.req  = (state_q == F_REQ);
    assign ibus.addr = pc_q;

    assign fq.instr = instr_q;
    assign fq.pc    = pc_q;
    assign fq.valid = (state_q == F_PRESENT);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= F_IDLE;
            pc_q    <= BOOT_ADDR;
        end else begin
            case (state_q)
                F_IDLE: begin
                    if (fetch_enable_i) begin
                        state_q <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (ibus.gnt) begin
                        state_q <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    if (ibus.rvalid) begin
                        state_q <= F_PRESENT;
                    end
                end
                F_PRESENT: begin
                    // the instruction stays presented until execute retires it
                    if (fq.done) begin
                        pc_q    <= fq.redirect ? fq.target : pc_q + 32'd4;
                        state_q <= fetch_enable_i ? F_REQ : F_IDLE;
                    end
                end
                default: state_q <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == F_WAIT) && ibus.rvalid) begin
            instr_q <= ibus.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== exec_unit.sv ====
// Instruction decode, register file, ALU, branch resolution and data-bus loads and stores
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic           clk_i,
    input  logic           arst_n_i,
    fetch_if.exec          fq,
    mem_bus_if.data_master dbus
);
    import core_isa_pkg::*;

    ex_state_e         state_q;
    logic [XLEN-1:0]   regs_q [NUM_REGS];

    op_e               op;
    logic [REG_AW-1:0] rd_idx;
    logic [REG_AW-1:0] rs_idx;
    logic [IMM_W-1:0]  imm;
    logic [XLEN-1:0]   imm_sext;
    logic [XLEN-1:0]   rd_val;
    logic [XLEN-1:0]   rs_val;
    logic [XLEN-1:0]   alu_res;
    logic              alu_wr;
    logic              is_mem;
    logic              taken;
    logic              done;

    // decode straight from the presented word, which fetch holds until done
    assign op       = op_e'(fq.instr[OPC_MSB -: OPC_W]);
    assign rd_idx   = fq.instr[RD_LSB +: REG_AW];
    assign rs_idx   = fq.instr[RS_LSB +: REG_AW];
    assign imm      = fq.instr[IMM_W-1:0];
    assign imm_sext = {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};

    assign rd_val = regs_q[rd_idx];
    assign rs_val = regs_q[rs_idx];

    always_comb begin
        alu_res = rd_val;
        alu_wr  = 1'b0;
        case (op)
            OP_LDI: begin
                alu_res = imm_sext;
                alu_wr  = 1'b1;
            end
            OP_LUI: begin
                alu_res = {imm, {(XLEN-IMM_W){1'b0}}};
                alu_wr  = 1'b1;
            end
            OP_ADD: begin
                alu_res = rd_val + rs_val;
                alu_wr  = 1'b1;
            end
            OP_SUB: begin
                alu_res = rd_val - rs_val;
                alu_wr  = 1'b1;
            end
            OP_XOR: begin
                alu_res = rd_val ^ rs_val;
                alu_wr  = 1'b1;
            end
            default: alu_wr = 1'b0;
        endcase
    end

    assign is_mem = (op == OP_LW) || (op == OP_SW);
    assign taken  = (op == OP_BNE) && (rd_val != rs_val);

    // register ops retire in EX_RUN, memory ops on the response from the RAM
    assign done = ((state_q == EX_RUN) && !is_mem) ||
                  ((state_q == EX_MEM_WAIT) && dbus.rvalid);

    assign fq.done     = done;
    assign fq.redirect = done && taken;
    assign fq.target   = fq.pc + (imm_sext << 2);

    assign dbus.req   = (state_q == EX_RUN) && is_mem;
    assign dbus.addr  = rs_val + imm_sext;
    assign dbus.we    = (op == OP_SW);
    assign dbus.wdata = rd_val;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= EX_IDLE;
        end else begin
            case (state_q)
                EX_IDLE: begin
                    if (fq.valid) begin
                        state_q <= EX_RUN;
                    end
                end
                EX_RUN: begin
                    if (!is_mem) begin
                        state_q <= EX_IDLE;
                    end else if (dbus.gnt) begin
                        state_q <= EX_MEM_WAIT;
                    end
                end
                EX_MEM_WAIT: begin
                    if (dbus.rvalid) begin
                        state_q <= EX_IDLE;
                    end
                end
                default: state_q <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (done) begin
            if (op == OP_LW) begin
                regs_q[rd_idx] <= dbus.rdata;
            end else if (alu_wr) begin
                regs_q[rd_idx] <= alu_res;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mm_ram.sv ====
// Dual-port RAM with program-load port, data address decode and pseudo-peripheral status registers
`timescale 1ns/1ps
`default_nettype none

module mm_ram (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    mem_bus_if.instr_slave                 ibus,
    mem_bus_if.data_slave                  dbus,
    input  logic                           prog_we_i,
    input  logic [mem_map_pkg::RAM_AW-1:0] prog_addr_i,
    input  logic [31:0]                    prog_data_i,
    output logic                           tests_passed_o,
    output logic                           tests_failed_o,
    output logic [31:0]                    exit_value_o,
    output logic                           exit_valid_o
);
    import mem_map_pkg::*;

    logic [31:0]       mem_q [RAM_WORDS];

    logic [RAM_AW-1:0] i_idx;
    logic [RAM_AW-1:0] d_idx;
    logic              i_in_ram;
    logic              d_in_ram;
    logic              d_is_status;
    logic              d_is_exit;
    logic              d_wr;

    logic [31:0]       i_rdata_q;
    logic [31:0]       d_rdata_q;
    logic              i_rvalid_q;
    logic              d_rvalid_q;

    logic              passed_q;
    logic              failed_q;
    logic [31:0]       exit_value_q;
    logic              exit_valid_q;

    // both ports accept every request at once and answer on the next clock
    assign ibus.gnt    = ibus.req;
    assign ibus.rvalid = i_rvalid_q;
    assign ibus.rdata  = i_rdata_q;
    assign dbus.gnt    = dbus.req;
    assign dbus.rvalid = d_rvalid_q;
    assign dbus.rdata  = d_rdata_q;

    assign i_idx       = ibus.addr[WORD_LSB +: RAM_AW];
    assign d_idx       = dbus.addr[WORD_LSB +: RAM_AW];
    assign i_in_ram    = (ibus.addr < RAM_BYTES);
    assign d_in_ram    = (dbus.addr < RAM_BYTES);
    assign d_is_status = (dbus.addr == STATUS_ADDR);
    assign d_is_exit   = (dbus.addr == EXIT_ADDR);
    assign d_wr        = dbus.req && dbus.we;

    // unmapped reads return zero, peripheral registers included
    always_ff @(posedge clk_i) begin
        if (d_wr && d_in_ram) begin
            mem_q[d_idx] <= dbus.wdata;
        end else if (prog_we_i) begin
            mem_q[prog_addr_i] <= prog_data_i;
        end
        if (ibus.req) begin
            i_rdata_q <= i_in_ram ? mem_q[i_idx] : '0;
        end
        if (dbus.req) begin
            d_rdata_q <= (d_in_ram && !dbus.we) ? mem_q[d_idx] : '0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            i_rvalid_q   <= 1'b0;
            d_rvalid_q   <= 1'b0;
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
            exit_value_q <= '0;
            exit_valid_q <= 1'b0;
        end else begin
            i_rvalid_q   <= ibus.req;
            d_rvalid_q   <= dbus.req;
            exit_valid_q <= d_wr && d_is_exit;
            if (d_wr && d_is_exit) begin
                exit_value_q <= dbus.wdata;
            end
            // the first verdict written sticks until the next reset
            if (d_wr && d_is_status && !passed_q && !failed_q) begin
                if (dbus.wdata == PASS_CODE) begin
                    passed_q <= 1'b1;
                end else begin
                    failed_q <= 1'b1;
                end
            end
        end
    end

    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_value_o   = exit_value_q;
    assign exit_valid_o   = exit_valid_q;

endmodule

`default_nettype wire

// ==== core_mem_subsystem.sv ====
// Subsystem top joining the fetch unit, execute unit and memory over internal buses
`timescale 1ns/1ps
`default_nettype none

module core_mem_subsystem (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           fetch_enable_i,

    // program loading is only meaningful while fetch is disabled
    input  logic                           prog_we_i,
    input  logic [mem_map_pkg::RAM_AW-1:0] prog_addr_i,
    input  logic [31:0]                    prog_data_i,

    output logic                           tests_passed_o,
    output logic                           tests_failed_o,
    output logic [31:0]                    exit_value_o,
    output logic                           exit_valid_o
);

    // one bus per core port, plus the fetch to execute handoff
    mem_bus_if ibus ();
    mem_bus_if dbus ();
    fetch_if   fq ();

    fetch_unit fetch_unit_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .fetch_enable_i (fetch_enable_i),
        .ibus           (ibus),
        .fq             (fq)
    );

    exec_unit exec_unit_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .fq       (fq),
        .dbus     (dbus)
    );

    // RAM and the memory-mapped status and exit registers
    mm_ram ram_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .ibus           (ibus),
        .dbus           (dbus),
        .prog_we_i      (prog_we_i),
        .prog_addr_i    (prog_addr_i),
        .prog_data_i    (prog_data_i),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_value_o   (exit_value_o),
        .exit_valid_o   (exit_valid_o)
    );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Free-running testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    // half of the 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk_o = 1'b0;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== subsystem_props.sv ====
// Bound assertions on memory bus handshakes, exit pulse width and status outputs
`timescale 1ns/1ps
`default_nettype none

module subsystem_props (
    input logic        clk_i,
    input logic        arst_n_i,
    input logic        i_req_i,
    input logic        i_gnt_i,
    input logic        i_rvalid_i,
    input logic [31:0] i_addr_i,
    input logic        d_req_i,
    input logic        d_gnt_i,
    input logic        d_rvalid_i,
    input logic [31:0] d_addr_i,
    input logic        tests_passed_i,
    input logic        tests_failed_i,
    input logic [31:0] exit_value_i,
    input logic        exit_valid_i
);

    // high once reset has been seen low on a previous clock
    logic in_reset_q;

    always_ff @(posedge clk_i) begin
        in_reset_q <= !arst_n_i;
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i) i_gnt_i |-> i_req_i)
        else $error("instruction grant without a request");
    assert property (@(posedge clk_i) disable iff (!arst_n_i) d_gnt_i |-> d_req_i)
        else $error("data grant without a request");

    // a response comes exactly one cycle after each grant and at no other time
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        i_rvalid_i == $past(i_req_i && i_gnt_i))
        else $error("instruction rvalid not one cycle after grant");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        d_rvalid_i == $past(d_req_i && d_gnt_i))
        else $error("data rvalid not one cycle after grant");

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (i_req_i && !i_gnt_i) |=> (i_req_i && $stable(i_addr_i)))
        else $error("instruction request changed before grant");
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (d_req_i && !d_gnt_i) |=> (d_req_i && $stable(d_addr_i)))
        else $error("data request changed before grant");

    assert property (@(posedge clk_i) disable iff (!arst_n_i) exit_valid_i |=> !exit_valid_i)
        else $error("exit valid longer than one cycle");
    assert property (@(posedge clk_i) !(tests_passed_i && tests_failed_i))
        else $error("passed and failed flags both set");

    assert property (@(posedge clk_i) (in_reset_q && !arst_n_i) |->
        (!i_req_i && !d_req_i && !tests_passed_i && !tests_failed_i &&
         !exit_valid_i && exit_value_i == 32'h0))
        else $error("outputs not cleared during reset");

endmodule

bind core_mem_subsystem subsystem_props props_i (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .i_req_i        (ibus.req),
    .i_gnt_i        (ibus.gnt),
    .i_rvalid_i     (ibus.rvalid),
    .i_addr_i       (ibus.addr),
    .d_req_i        (dbus.req),
    .d_gnt_i        (dbus.gnt),
    .d_rvalid_i     (dbus.rvalid),
    .d_addr_i       (dbus.addr),
    .tests_passed_i (tests_passed_o),
    .tests_failed_i (tests_failed_o),
    .exit_value_i   (exit_value_o),
    .exit_valid_i   (exit_valid_o)
);

`default_nettype wire

// ==== tb_top.sv ====
// Testbench top with program assembly, loading, ISA reference model, tests and reporting
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import core_isa_pkg::*;
    import mem_map_pkg::*;

    localparam int NUM_TESTS      = 6;
    localparam int TEST_CYCLES    = 400;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_CYCLES;
    localparam int MODEL_STEPS    = 1000;

    logic              clk;
    logic              arst_n;
    logic              fetch_enable;
    logic              prog_we;
    logic [RAM_AW-1:0] prog_addr;
    logic [31:0]       prog_data;
    logic              tests_passed;
    logic              tests_failed;
    logic [31:0]       exit_value;
    logic              exit_valid;

    logic [31:0]       prog_mem [RAM_WORDS];
    int                prog_len;
    logic [31:0]       model_addr;
    logic [31:0]       model_value;
    logic              model_done;
    int                error_count = 0;
    int                pass_count = 0;
    int                fail_count = 0;
    int                cycle_count = 0;

    tb_clock_gen clock_gen_i (.clk_o(clk));

    core_mem_subsystem core_mem_subsystem_i (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .fetch_enable_i (fetch_enable),
        .prog_we_i      (prog_we),
        .prog_addr_i    (prog_addr),
        .prog_data_i    (prog_data),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed),
        .exit_value_o   (exit_value),
        .exit_valid_o   (exit_valid)
    );

    function automatic logic [31:0] encode_instr(op_e op, int rd, int rs, logic [15:0] imm);
        logic [31:0] w;
        w = '0;
        w[OPC_MSB -: 4]  = op;
        w[RD_LSB +: 2]   = 2'(rd);
        w[RS_LSB +: 2]   = 2'(rs);
        w[IMM_W-1:0]     = imm;
        return w;
    endfunction

    task automatic append_instr(op_e op, int rd, int rs, logic [15:0] imm);
        prog_mem[prog_len] = encode_instr(op, rd, rs, imm);
        prog_len++;
    endtask

    // LDI sign-extends, so the upper half is pre-flipped when bit 15 is set
    task automatic append_const(int rd, int tmp, logic [31:0] v);
        append_instr(OP_LUI, rd, 0, v[31:16] ^ (v[15] ? 16'hFFFF : 16'h0000));
        append_instr(OP_LDI, tmp, 0, v[15:0]);
        append_instr(OP_XOR, rd, tmp, 16'h0000);
    endtask

    // r3 is used as the peripheral base register
    task automatic append_store(int rd, logic [31:0] addr);
        append_instr(OP_LUI, 3, 0, addr[31:16]);
        append_instr(OP_SW, rd, 3, addr[15:0]);
    endtask

    task automatic build_alu_chain();
        prog_len = 0;
        append_instr(OP_LDI, 0, 0, 16'h8421);
        append_instr(OP_LUI, 1, 0, 16'h0F0F);
        append_instr(OP_ADD, 1, 0, 16'h0000);
        append_instr(OP_LDI, 2, 0, 16'h0765);
        append_instr(OP_SUB, 1, 2, 16'h0000);
        append_instr(OP_XOR, 1, 0, 16'h0000);
        append_store(1, EXIT_ADDR);
    endtask

    task automatic flag_error(string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    // interprets the ISA on its own copy of the program until the first peripheral store
    task automatic run_model();
        logic [31:0] mem [RAM_WORDS];
        logic [31:0] r [NUM_REGS];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] sx;
        logic [31:0] ea;
        logic [31:0] pc_next;
        logic [1:0]  rd;
        logic [1:0]  rs;
        op_e         op;
        int          steps;
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = (i < prog_len) ? prog_mem[i] : 32'h0;
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            r[i] = 32'h0;
        end
        pc = BOOT_ADDR;
        steps = 0;
        model_done = 1'b0;
        while (!model_done && steps < MODEL_STEPS) begin
            ins = (pc < RAM_BYTES) ? mem[pc[WORD_LSB +: RAM_AW]] : 32'h0;
            op = op_e'(ins[OPC_MSB -: 4]);
            rd = ins[RD_LSB +: 2];
            rs = ins[RS_LSB +: 2];
            sx = {{16{ins[15]}}, ins[15:0]};
            ea = r[rs] + sx;
            pc_next = pc + 32'd4;
            case (op)
                OP_LDI: r[rd] = sx;
                OP_LUI: r[rd] = {ins[15:0], 16'h0000};
                OP_ADD: r[rd] = r[rd] + r[rs];
                OP_SUB: r[rd] = r[rd] - r[rs];
                OP_XOR: r[rd] = r[rd] ^ r[rs];
                OP_LW:  r[rd] = (ea < RAM_BYTES) ? mem[ea[WORD_LSB +: RAM_AW]] : 32'h0;
                OP_SW: begin
                    if (ea == EXIT_ADDR || ea == STATUS_ADDR) begin
                        model_done  = 1'b1;
                        model_addr  = ea;
                        model_value = r[rd];
                    end else if (ea < RAM_BYTES) begin
                        mem[ea[WORD_LSB +: RAM_AW]] = r[rd];
                    end
                end
                OP_BNE: begin
                    if (r[rd] != r[rs]) begin
                        pc_next = pc + (sx << 2);
                    end
                end
                default: ;
            endcase
            pc = pc_next;
            steps++;
        end
    endtask

    task automatic check_outcome();
        logic exp_exit;
        logic exp_pass;
        logic exp_fail;
        run_model();
        if (!model_done) begin
            $display("reference model never reached a status or exit store");
            error_count++;
        end
        exp_exit = (model_addr == EXIT_ADDR);
        exp_pass = (model_addr == STATUS_ADDR) && (model_value == PASS_CODE);
        exp_fail = (model_addr == STATUS_ADDR) && !exp_pass;
        assert (exit_valid == exp_exit)
            else flag_error($sformatf("exit_valid_o is %b, expected %b", exit_valid, exp_exit));
        assert (!exp_exit || exit_value == model_value)
            else flag_error($sformatf("exit value %h, expected %h", exit_value, model_value));
        assert (tests_passed == exp_pass)
            else flag_error($sformatf("tests_passed_o is %b, expected %b", tests_passed, exp_pass));
        assert (tests_failed == exp_fail)
            else flag_error($sformatf("tests_failed_o is %b, expected %b", tests_failed, exp_fail));
    endtask

    // reset, load through the prog port, then run until the program reports its end
    task automatic run_program(bit hold_off);
        arst_n = 1'b0;
        fetch_enable = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < prog_len; i++) begin
            prog_we   = 1'b1;
            prog_addr = RAM_AW'(i);
            prog_data = prog_mem[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        if (hold_off) begin
            repeat (50) begin
                @(negedge clk);
                assert (!exit_valid && !tests_passed && !tests_failed)
                    else flag_error("program finished while fetch was disabled");
            end
        end
        fetch_enable = 1'b1;
        do @(negedge clk); while (!(exit_valid || tests_passed || tests_failed));
        fetch_enable = 1'b0;
        check_outcome();
    endtask

    task automatic finish_test(int num, string name, int errs_before);
        if (error_count == errs_before) begin
            pass_count++;
            $display("test %0d %s: passed", num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed", num, name);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles before all tests finished", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int  errs;
        int  n;
        op_e op;
        void'($urandom(17));
        arst_n       = 1'b0;
        fetch_enable = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;

        errs = error_count;
        build_alu_chain();
        run_program(1'b0);
        finish_test(1, "alu chain", errs);

        errs = error_count;
        prog_len = 0;
        append_const(0, 3, 32'hCAFE_1234);
        append_instr(OP_LDI, 1, 0, 16'h0200);
        append_instr(OP_SW, 0, 1, 16'h0000);
        append_instr(OP_LW, 2, 1, 16'h0000);
        append_store(2, EXIT_ADDR);
        run_program(1'b0);
        finish_test(2, "load store", errs);

        // counter runs from n+1 down to 1, so the body runs n times
        errs = error_count;
        n = 3 + int'($urandom % 6);
        prog_len = 0;
        append_instr(OP_LDI, 0, 0, 16'(n + 1));
        append_instr(OP_LDI, 1, 0, 16'h0000);
        append_instr(OP_LDI, 2, 0, 16'h0013);
        append_instr(OP_LDI, 3, 0, 16'h0001);
        append_instr(OP_ADD, 1, 2, 16'h0000);
        append_instr(OP_SUB, 0, 3, 16'h0000);
        append_instr(OP_BNE, 0, 3, 16'hFFFE);
        append_store(1, EXIT_ADDR);
        run_program(1'b0);
        finish_test(3, "branch loop", errs);

        errs = error_count;
        for (int k = 0; k < 2; k++) begin
            prog_len = 0;
            append_const(0, 3, PASS_CODE + 32'(k));
            append_store(0, STATUS_ADDR);
            run_program(1'b0);
        end
        finish_test(4, "status flags", errs);

        errs = error_count;
        repeat (5) begin
            prog_len = 0;
            append_const(0, 3, $urandom);
            append_const(1, 3, $urandom);
            append_instr(OP_LDI, 2, 0, 16'($urandom));
            repeat (4) begin
                case ($urandom % 3)
                    0: op = OP_ADD;
                    1: op = OP_SUB;
                    default: op = OP_XOR;
                endcase
                append_instr(op, int'($urandom % 3), int'($urandom % 3), 16'h0000);
            end
            append_store(int'($urandom % 3), EXIT_ADDR);
            run_program(1'b0);
        end
        finish_test(5, "random operands", errs);

        errs = error_count;
        build_alu_chain();
        run_program(1'b1);
        finish_test(6, "fetch hold-off", errs);

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
core_isa_pkg.sv
mem_map_pkg.sv
mem_bus_if.sv
fetch_if.sv
fetch_unit.sv
exec_unit.sv
mm_ram.sv
core_mem_subsystem.sv
tb_clock_gen.sv
subsystem_props.sv
tb_top.sv

// ==== Makefile ====
TOP := tb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir sim.log
